// File: Makefile
VERILATOR  ?= verilator
TOP        ?= agu_tb
RTL_TOP    ?= agu_top
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
RUN_ARGS   ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "^SIMULATION PASSED$$"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
+incdir+verilog
verilog/agu_pkg.sv
verilog/agu_addr_gen.sv
verilog/agu_amo_fsm.sv
verilog/agu_amo_alu.sv
verilog/agu_amo_buf.sv
verilog/agu_top.sv
tb/agu_checker.sv
tb/agu_tb.sv

// File: tb/agu_checker.sv
`timescale 1ns/10ps
`default_nettype none

module agu_checker (
	input logic           clk,
	input logic           rst,
	input logic           icb_cmd_valid,
	input logic           icb_cmd_ready,
	input agu_pkg::addr_t icb_cmd_addr,
	input agu_pkg::xlen_t icb_cmd_wdata,
	input logic           icb_cmd_read,
	input logic           icb_cmd_lock,
	input logic           o_valid,
	input logic           o_cmt_misalgn
);

	int unsigned assert_fails = 0; // read by the testbench at the end

	// stalled command keeps its fields
	cmd_stall_stable: assert property (@(posedge clk) disable iff (rst)
		(icb_cmd_valid && !icb_cmd_ready) |=>
			(icb_cmd_valid && $stable(icb_cmd_addr) && $stable(icb_cmd_wdata)))
	else begin
		$error("bus command changed or dropped while stalled");
		assert_fails = assert_fails + 1;
	end

	lock_on_read: assert property (@(posedge clk) disable iff (rst)
		icb_cmd_lock |-> icb_cmd_read)
	else begin
		$error("locked bus command is not a read");
		assert_fails = assert_fails + 1;
	end

	// misaligned result never goes out together with a command
	misalgn_no_cmd: assert property (@(posedge clk) disable iff (rst)
		(o_valid && o_cmt_misalgn) |-> !icb_cmd_valid)
	else begin
		$error("bus command issued for a misaligned instruction");
		assert_fails = assert_fails + 1;
	end

endmodule

bind agu_top agu_checker chk0 (
	.clk           (clk),
	.rst           (rst),
	.icb_cmd_valid (icb_cmd_valid),
	.icb_cmd_ready (icb_cmd_ready),
	.icb_cmd_addr  (icb_cmd_addr),
	.icb_cmd_wdata (icb_cmd_wdata),
	.icb_cmd_read  (icb_cmd_read),
	.icb_cmd_lock  (icb_cmd_lock),
	.o_valid       (o_valid),
	.o_cmt_misalgn (o_cmt_misalgn)
);

`default_nettype wire

// File: tb/agu_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "agu_settings.svh"

module agu_tb;

	localparam int NUM_TESTS = 6;

	logic clk;
	logic rst;
	logic i_valid;
	logic i_ready;
	agu_pkg::agu_op_t i_op;
	agu_pkg::size_t i_size;
	agu_pkg::amo_op_t i_amo_op;
	agu_pkg::xlen_t i_rs1, i_rs2, i_imm;
	logic oitf_empty;
	logic amo_wait;
	logic o_valid;
	logic o_ready;
	agu_pkg::xlen_t o_wbck_wdat;
	logic o_wbck_err, o_cmt_misalgn, o_cmt_buserr, o_cmt_ld, o_cmt_stamo;
	agu_pkg::addr_t o_cmt_badaddr;
	logic icb_cmd_valid;
	logic icb_cmd_ready;
	agu_pkg::addr_t icb_cmd_addr;
	logic icb_cmd_read;
	agu_pkg::xlen_t icb_cmd_wdata;
	agu_pkg::wmask_t icb_cmd_wmask;
	logic icb_cmd_lock;
	agu_pkg::size_t icb_cmd_size;
	logic icb_rsp_valid;
	logic icb_rsp_err;
	agu_pkg::xlen_t icb_rsp_rdata;

	int tests = 0;
	int checks = 0;
	int errors = 0;
	logic [31:0] seed = 32'h7d6de2be;

	// memory model and the log of accepted commands
	agu_pkg::xlen_t mem [agu_pkg::addr_t];
	agu_pkg::addr_t log_addr[$];
	logic log_read[$];
	logic log_lock[$];
	agu_pkg::size_t log_size[$];
	agu_pkg::xlen_t log_wdata[$];
	agu_pkg::wmask_t log_wmask[$];
	logic inject_err;
	logic rsp_pend;
	logic rsp_err_q;
	agu_pkg::xlen_t rsp_data;
	int rsp_wait;
	int ready_wait;

	// outputs captured at the issue handshake
	logic r_valid, r_err, r_misalgn, r_buserr, r_ld, r_stamo;
	agu_pkg::xlen_t r_wdat;
	agu_pkg::addr_t r_badaddr;

	agu_top dut0 (.*);

	always #10 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function logic [31:0] next_rand();
		seed = xorshift(seed);
		return seed;
	endfunction

	function automatic agu_pkg::xlen_t mem_read(input agu_pkg::addr_t a);
		agu_pkg::addr_t k;
		k = {a[31:2], 2'b00};
		if (mem.exists(k))
			return mem[k];
		return k ^ {k[15:0], k[31:16]} ^ 32'h3c96a55a; // untouched words
	endfunction

	task automatic mem_write(input agu_pkg::addr_t a, input agu_pkg::xlen_t d,
		input agu_pkg::wmask_t m);
		agu_pkg::xlen_t w;
		w = mem_read(a);
		for (int b = 0; b < `AGU_MASK_W; b++) begin
			if (m[b])
				w[8*b +: 8] = d[8*b +: 8];
		end
		mem[{a[31:2], 2'b00}] = w;
	endtask

	// responder: take the command mid-cycle, answer a few cycles later
	always @(negedge clk) begin
		if (!rst && icb_cmd_valid && icb_cmd_ready) begin
			log_addr.push_back(icb_cmd_addr);
			log_read.push_back(icb_cmd_read);
			log_lock.push_back(icb_cmd_lock);
			log_size.push_back(icb_cmd_size);
			log_wdata.push_back(icb_cmd_wdata);
			log_wmask.push_back(icb_cmd_wmask);
			rsp_data = mem_read(icb_cmd_addr);
			rsp_err_q = inject_err & icb_cmd_read;
			if (!icb_cmd_read)
				mem_write(icb_cmd_addr, icb_cmd_wdata, icb_cmd_wmask);
			rsp_pend = 1'b1;
			rsp_wait = int'(next_rand() % 3);
			ready_wait = int'(next_rand() % 3);
		end
	end

	always @(posedge clk) begin
		#2;
		icb_rsp_valid = 1'b0;
		icb_rsp_err = 1'b0;
		if (rsp_pend) begin
			if (rsp_wait == 0) begin
				icb_rsp_valid = 1'b1;
				icb_rsp_err = rsp_err_q;
				icb_rsp_rdata = rsp_data;
				rsp_pend = 1'b0;
			end else
				rsp_wait--;
		end
		if (rsp_pend || icb_rsp_valid)
			icb_cmd_ready = 1'b0; // one command outstanding
		else if (ready_wait != 0) begin
			icb_cmd_ready = 1'b0;
			ready_wait--;
		end else
			icb_cmd_ready = 1'b1;
	end

	task automatic check_word(input string name, input agu_pkg::xlen_t got,
		input agu_pkg::xlen_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input agu_pkg::addr_t got,
		input agu_pkg::addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_mask(input string name, input agu_pkg::wmask_t got,
		input agu_pkg::wmask_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_size(input string name, input agu_pkg::size_t got,
		input agu_pkg::size_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// pops one logged command and compares address, direction, lock and size
	task automatic check_cmd(input agu_pkg::addr_t addr, input logic read, input logic lock,
		input agu_pkg::size_t size, output agu_pkg::xlen_t wdata,
		output agu_pkg::wmask_t wmask);
		wdata = '0;
		wmask = '0;
		if (log_addr.size() == 0) begin
			errors++;
			$display("expected a bus command at %h but none was issued", addr);
			return;
		end
		check_addr("icb_cmd_addr", log_addr.pop_front(), addr);
		check_bit("icb_cmd_read", log_read.pop_front(), read);
		check_bit("icb_cmd_lock", log_lock.pop_front(), lock);
		check_size("icb_cmd_size", log_size.pop_front(), size);
		wdata = log_wdata.pop_front();
		wmask = log_wmask.pop_front();
	endtask

	task automatic drive_req(input agu_pkg::agu_op_t op, input agu_pkg::size_t size,
		input agu_pkg::amo_op_t aop, input agu_pkg::xlen_t rs1, input agu_pkg::xlen_t rs2,
		input agu_pkg::xlen_t imm);
		i_op = op;
		i_size = size;
		i_amo_op = aop;
		i_rs1 = rs1;
		i_rs2 = rs2;
		i_imm = imm;
		i_valid = 1'b1;
	endtask

	// waits for i_valid and i_ready, watching stalls and amo_wait on the way
	task automatic wait_handshake();
		logic locked;
		logic stalled;
		agu_pkg::addr_t stall_addr;
		int n;
		locked = 1'b0;
		stalled = 1'b0;
		stall_addr = '0;
		n = 0;
		forever begin
			@(negedge clk);
			if (stalled) begin
				check_bit("icb_cmd_valid", icb_cmd_valid, 1'b1);
				check_addr("icb_cmd_addr", icb_cmd_addr, stall_addr);
			end
			if (locked)
				check_bit("amo_wait", amo_wait, 1'b1);
			stalled = icb_cmd_valid & ~icb_cmd_ready;
			stall_addr = icb_cmd_addr;
			if (icb_cmd_valid && icb_cmd_ready && icb_cmd_lock)
				locked = 1'b1;
			if (i_valid && i_ready)
				break;
			n++;
			if (n > 500) begin
				errors++;
				$display("timed out waiting for the issue handshake");
				break;
			end
		end
		r_valid = o_valid;
		r_wdat = o_wbck_wdat;
		r_err = o_wbck_err;
		r_misalgn = o_cmt_misalgn;
		r_buserr = o_cmt_buserr;
		r_ld = o_cmt_ld;
		r_stamo = o_cmt_stamo;
		r_badaddr = o_cmt_badaddr;
		@(posedge clk);
		#2;
		i_valid = 1'b0;
	endtask

	task automatic issue(input agu_pkg::agu_op_t op, input agu_pkg::size_t size,
		input agu_pkg::amo_op_t aop, input agu_pkg::xlen_t rs1, input agu_pkg::xlen_t rs2,
		input agu_pkg::xlen_t imm);
		drive_req(op, size, aop, rs1, rs2, imm);
		wait_handshake();
	endtask

	// lets the responder finish its last answer
	task automatic settle();
		do
			@(negedge clk);
		while (rsp_pend || icb_rsp_valid);
		@(posedge clk);
		#2;
	endtask

	task automatic end_test(input string name, input int start);
		tests++;
		$display("test %s finished with %0d errors", name, errors - start);
	endtask

	function automatic agu_pkg::xlen_t lane_data(input int size, input agu_pkg::xlen_t v);
		if (size == 0)
			return {4{v[7:0]}};
		if (size == 1)
			return {2{v[15:0]}};
		return v;
	endfunction

	function automatic agu_pkg::xlen_t amo_expect(input agu_pkg::amo_op_t op,
		input agu_pkg::xlen_t old, input agu_pkg::xlen_t v);
		int signed so;
		int signed sv;
		so = old;
		sv = v;
		case (op)
			agu_pkg::AMO_SWAP: return v;
			agu_pkg::AMO_ADD:  return old + v;
			agu_pkg::AMO_AND:  return old & v;
			agu_pkg::AMO_OR:   return old | v;
			agu_pkg::AMO_XOR:  return old ^ v;
			agu_pkg::AMO_MAX:  return (so > sv) ? old : v;
			agu_pkg::AMO_MIN:  return (so < sv) ? old : v;
			agu_pkg::AMO_MAXU: return (old > v) ? old : v;
			agu_pkg::AMO_MINU: return (old < v) ? old : v;
			default:           return old;
		endcase
	endfunction

	task automatic test_reset();
		int start;
		start = errors;
		@(negedge clk);
		check_bit("icb_cmd_valid", icb_cmd_valid, 1'b0);
		check_bit("o_valid", o_valid, 1'b0);
		check_bit("amo_wait", amo_wait, 1'b0);
		check_bit("i_ready", i_ready, 1'b0);
		@(posedge clk);
		#2;
		end_test("reset", start);
	endtask

	task automatic test_ldst();
		agu_pkg::xlen_t rs1, rs2, imm, r, wd;
		agu_pkg::agu_op_t op;
		agu_pkg::wmask_t wm;
		agu_pkg::wmask_t size_m;
		int start;
		start = errors;
		for (int o = 0; o < 2; o++) begin
			for (int s = 0; s < 3; s++) begin
				for (int off = 0; off < 4; off += (1 << s)) begin
					op = (o == 1) ? agu_pkg::OP_STORE : agu_pkg::OP_LOAD;
					rs1 = next_rand() & ~32'h3;
					rs2 = next_rand();
					r = next_rand();
					imm = {{20{r[11]}}, r[11:2], 2'b00} + off; // signed 12-bit offset
					size_m = (s == 0) ? 4'b0001 : (s == 1) ? 4'b0011 : 4'b1111;
					issue(op, agu_pkg::size_t'(s), agu_pkg::AMO_SWAP, rs1, rs2, imm);
					settle();
					check_cmd(rs1 + imm, o == 0, 1'b0, agu_pkg::size_t'(s), wd, wm);
					if (o == 1) begin
						check_word("icb_cmd_wdata", wd, lane_data(s, rs2));
						check_mask("icb_cmd_wmask", wm, size_m << off);
					end
					check_bit("o_valid", r_valid, 1'b1);
					check_bit("o_cmt_misalgn", r_misalgn, 1'b0);
					check_bit("o_cmt_ld", r_ld, o == 0);
					check_bit("o_cmt_stamo", r_stamo, o == 1);
					check_addr("o_cmt_badaddr", r_badaddr, rs1 + imm);
					check_word("o_wbck_wdat", r_wdat, '0);
				end
			end
		end
		end_test("ldst_aligned", start);
	endtask

	task automatic test_misaligned();
		agu_pkg::xlen_t rs1, imm, r;
		agu_pkg::addr_t exp;
		agu_pkg::agu_op_t op;
		int n, start;
		start = errors;
		for (int o = 0; o < 3; o++) begin
			for (int s = 1; s < 3; s++) begin
				for (int off = 1; off < 4; off++) begin
					if ((s == 1 && off == 2) || (o == 2 && s == 1))
						continue;
					op = (o == 0) ? agu_pkg::OP_LOAD
						: (o == 1) ? agu_pkg::OP_STORE : agu_pkg::OP_AMO;
					rs1 = next_rand() & ~32'h3;
					r = next_rand();
					imm = {{20{r[11]}}, r[11:2], 2'b00} + off;
					if (o == 2) begin
						rs1 = rs1 + off; // offset ignored for atomics
						exp = rs1;
					end else
						exp = rs1 + imm;
					n = log_addr.size();
					issue(op, agu_pkg::size_t'(s), agu_pkg::AMO_ADD, rs1, next_rand(), imm);
					settle();
					if (log_addr.size() != n) begin
						errors++;
						$display("a misaligned access at %h reached the bus", exp);
					end
					check_bit("o_valid", r_valid, 1'b1);
					check_bit("o_cmt_misalgn", r_misalgn, 1'b1);
					check_bit("o_wbck_err", r_err, 1'b1);
					check_bit("o_cmt_buserr", r_buserr, 1'b0);
					check_addr("o_cmt_badaddr", r_badaddr, exp);
				end
			end
		end
		end_test("misaligned", start);
	endtask

	task automatic test_amo_ops();
		agu_pkg::xlen_t rs1, rs2, old, exp, wd;
		agu_pkg::wmask_t wm;
		agu_pkg::amo_op_t op;
		int start;
		start = errors;
		for (int rep = 0; rep < 2; rep++) begin
			for (int k = 0; k < 9; k++) begin
				op = agu_pkg::amo_op_t'(k);
				rs1 = next_rand() & ~32'h3;
				rs2 = next_rand();
				old = next_rand();
				mem[rs1] = old;
				exp = amo_expect(op, old, rs2);
				issue(agu_pkg::OP_AMO, 2'd2, op, rs1, rs2, next_rand());
				settle();
				check_cmd(rs1, 1'b1, 1'b1, 2'd2, wd, wm); // locked read
				check_cmd(rs1, 1'b0, 1'b0, 2'd2, wd, wm);
				check_word("icb_cmd_wdata", wd, exp);
				check_mask("icb_cmd_wmask", wm, 4'hf);
				check_bit("o_valid", r_valid, 1'b1);
				check_word("o_wbck_wdat", r_wdat, old);
				check_bit("o_wbck_err", r_err, 1'b0);
				check_bit("o_cmt_stamo", r_stamo, 1'b1);
				check_word("mem", mem_read(rs1), exp);
			end
		end
		end_test("amo_ops", start);
	endtask

	task automatic test_amo_buserr();
		agu_pkg::xlen_t rs1, old, wd;
		agu_pkg::wmask_t wm;
		int start;
		start = errors;
		rs1 = next_rand() & ~32'h3;
		old = next_rand();
		mem[rs1] = old;
		inject_err = 1'b1;
		issue(agu_pkg::OP_AMO, 2'd2, agu_pkg::AMO_ADD, rs1, next_rand(), '0);
		settle();
		inject_err = 1'b0;
		check_cmd(rs1, 1'b1, 1'b1, 2'd2, wd, wm);
		check_cmd(rs1, 1'b0, 1'b0, 2'd2, wd, wm);
		check_mask("icb_cmd_wmask", wm, 4'h0);
		check_word("mem", mem_read(rs1), old);
		check_bit("o_cmt_buserr", r_buserr, 1'b1);
		check_bit("o_wbck_err", r_err, 1'b1);
		check_bit("o_cmt_misalgn", r_misalgn, 1'b0);
		end_test("amo_buserr", start);
	endtask

	task automatic test_backpressure();
		agu_pkg::xlen_t rs1, rs2, wd;
		agu_pkg::wmask_t wm;
		int start;
		start = errors;
		// o_ready low holds the store back
		o_ready = 1'b0;
		rs1 = next_rand() & ~32'h3;
		drive_req(agu_pkg::OP_STORE, 2'd2, agu_pkg::AMO_SWAP, rs1, next_rand(), 32'h10);
		repeat (4) begin
			@(negedge clk);
			check_bit("icb_cmd_valid", icb_cmd_valid, 1'b0);
			check_bit("i_ready", i_ready, 1'b0);
		end
		@(posedge clk);
		#2;
		o_ready = 1'b1;
		wait_handshake();
		settle();
		check_cmd(rs1 + 32'h10, 1'b0, 1'b0, 2'd2, wd, wm);
		// atomic waits for an empty oitf
		oitf_empty = 1'b0;
		drive_req(agu_pkg::OP_AMO, 2'd2, agu_pkg::AMO_OR, rs1, next_rand(), '0);
		repeat (4) begin
			@(negedge clk);
			check_bit("icb_cmd_valid", icb_cmd_valid, 1'b0);
			check_bit("amo_wait", amo_wait, 1'b0);
		end
		@(posedge clk);
		#2;
		oitf_empty = 1'b1;
		wait_handshake();
		settle();
		check_cmd(rs1, 1'b1, 1'b1, 2'd2, wd, wm);
		check_cmd(rs1, 1'b0, 1'b0, 2'd2, wd, wm);
		// store burst under random icb_cmd_ready delays
		repeat (8) begin
			rs1 = next_rand() & ~32'h3;
			rs2 = next_rand();
			issue(agu_pkg::OP_STORE, 2'd2, agu_pkg::AMO_SWAP, rs1, rs2, '0);
			settle();
			check_cmd(rs1, 1'b0, 1'b0, 2'd2, wd, wm);
			check_word("mem", mem_read(rs1), rs2);
		end
		end_test("backpressure", start);
	endtask

	initial begin
		repeat (NUM_TESTS * 2000) @(posedge clk);
		$display("watchdog expired before the tests finished");
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		i_valid = 1'b0;
		i_op = agu_pkg::OP_LOAD;
		i_size = '0;
		i_amo_op = agu_pkg::AMO_SWAP;
		i_rs1 = '0;
		i_rs2 = '0;
		i_imm = '0;
		oitf_empty = 1'b1;
		o_ready = 1'b1;
		icb_cmd_ready = 1'b0;
		icb_rsp_valid = 1'b0;
		icb_rsp_err = 1'b0;
		icb_rsp_rdata = '0;
		inject_err = 1'b0;
		rsp_pend = 1'b0;
		rsp_err_q = 1'b0;
		rsp_data = '0;
		rsp_wait = 0;
		ready_wait = 0;
		repeat (16) @(posedge clk);
		#2;
		rst = 1'b0;
		test_reset();
		test_ldst();
		test_misaligned();
		test_amo_ops();
		test_amo_buserr();
		test_backpressure();
		errors = errors + int'(dut0.chk0.assert_fails);
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/agu_addr_gen.sv
`timescale 1ns/10ps
`default_nettype none

`include "agu_settings.svh"

module agu_addr_gen (
	input  agu_pkg::agu_op_t i_op,
	input  agu_pkg::size_t   i_size,
	input  agu_pkg::xlen_t   i_rs1,
	input  agu_pkg::xlen_t   i_rs2,
	input  agu_pkg::xlen_t   i_imm,
	output agu_pkg::addr_t   addr,
	output logic             addr_unalgn,
	output agu_pkg::xlen_t   st_wdata,
	output agu_pkg::wmask_t  st_wmask
);

	agu_pkg::xlen_t  ofst;
	agu_pkg::xlen_t  sum;
	agu_pkg::wmask_t size_mask;
	logic            size_hw;
	logic            size_w;

	// atomics address rs1 directly
	assign ofst = (i_op == agu_pkg::OP_AMO) ? '0 : i_imm;
	assign sum  = i_rs1 + ofst;
	assign addr = sum[`AGU_ADDR_SIZE-1:0];

	assign size_hw = (i_size == 2'd1);
	assign size_w  = (i_size == 2'd2);

	// halfword needs bit 0 clear, word needs both low bits clear
	assign addr_unalgn = (size_hw & addr[0])
		| (size_w & (|addr[1:0]));

	always_comb begin
		case (i_size)
			2'd0: begin
				st_wdata  = {(`AGU_XLEN/8){i_rs2[7:0]}}; // byte in every lane
				size_mask = agu_pkg::wmask_t'(1);
			end
			2'd1: begin
				st_wdata  = {(`AGU_XLEN/16){i_rs2[15:0]}};
				size_mask = agu_pkg::wmask_t'(3);
			end
			default: begin
				st_wdata  = i_rs2;
				size_mask = '1;
			end
		endcase
	end

	// lanes follow the low address bits
	assign st_wmask = size_mask << addr[1:0];

endmodule

`default_nettype wire

// File: verilog/agu_amo_alu.sv
`timescale 1ns/10ps
`default_nettype none

module agu_amo_alu (
	input  agu_pkg::amo_op_t amo_op,
	input  agu_pkg::xlen_t   mem_val,
	input  agu_pkg::xlen_t   rs2,
	output agu_pkg::xlen_t   result
);

	logic mem_lt_s; // mem_val below rs2, signed
	logic mem_lt_u;

	assign mem_lt_s = $signed(mem_val) < $signed(rs2);
	assign mem_lt_u = mem_val < rs2;

	always_comb begin
		case (amo_op)
			agu_pkg::AMO_SWAP: result = rs2;
			agu_pkg::AMO_ADD:  result = mem_val + rs2;
			agu_pkg::AMO_AND:  result = mem_val & rs2;
			agu_pkg::AMO_OR:   result = mem_val | rs2;
			agu_pkg::AMO_XOR:  result = mem_val ^ rs2;
			agu_pkg::AMO_MAX:  result = mem_lt_s ? rs2 : mem_val;
			agu_pkg::AMO_MIN:  result = mem_lt_s ? mem_val : rs2;
			agu_pkg::AMO_MAXU: result = mem_lt_u ? rs2 : mem_val;
			agu_pkg::AMO_MINU: result = mem_lt_u ? mem_val : rs2;
			default:           result = mem_val; // leave memory as read
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/agu_amo_buf.sv
`timescale 1ns/10ps
`default_nettype none

module agu_amo_buf (
	input  logic                clk,
	input  logic                rst,
	input  agu_pkg::amo_state_t state,
	input  logic                rsp_valid,
	input  logic                rsp_err,
	input  agu_pkg::xlen_t      rsp_rdata,
	input  agu_pkg::xlen_t      alu_result,
	output agu_pkg::xlen_t      read_val,  // old memory value
	output agu_pkg::xlen_t      write_val,
	output logic                err
);

	logic first_rsp;
	logic second_rsp;

	assign first_rsp  = (state == agu_pkg::S_FIRST) & rsp_valid;
	assign second_rsp = (state == agu_pkg::S_SECOND) & rsp_valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			read_val  <= '0;
			write_val <= '0;
		end else begin
			if (first_rsp)
				read_val <= rsp_rdata;
			if (state == agu_pkg::S_ALU)
				write_val <= alu_result; // one cycle after the read data
		end
	end

	// error of the read, plus any error on the write
	always_ff @(posedge clk) begin
		if (rst)
			err <= 1'b0;
		else if (first_rsp)
			err <= rsp_err;
		else if (second_rsp)
			err <= err | rsp_err;
	end

endmodule

`default_nettype wire

// File: verilog/agu_amo_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module agu_amo_fsm (
	input  logic                clk,
	input  logic                rst,
	input  logic                start,       // read command taken in idle
	input  logic                addr_unalgn,
	input  logic                cmd_ready,
	input  logic                rsp_valid,
	input  logic                o_ready,
	output agu_pkg::amo_state_t state,
	output logic                unalgn_held,
	output logic                done
);

	agu_pkg::amo_state_t state_nxt;

	always_comb begin
		state_nxt = state;
		case (state)
			agu_pkg::S_IDLE: begin
				if (start)
					state_nxt = agu_pkg::S_FIRST;
			end
			agu_pkg::S_FIRST: begin
				if (rsp_valid)
					state_nxt = agu_pkg::S_ALU;
			end
			// alu and ready take one cycle each
			agu_pkg::S_ALU:   state_nxt = agu_pkg::S_READY;
			agu_pkg::S_READY: state_nxt = agu_pkg::S_WAIT_SECOND;
			agu_pkg::S_WAIT_SECOND: begin
				if (cmd_ready) // write command accepted
					state_nxt = agu_pkg::S_SECOND;
			end
			agu_pkg::S_SECOND: begin
				if (rsp_valid)
					state_nxt = agu_pkg::S_WBCK;
			end
			agu_pkg::S_WBCK: begin
				if (o_ready)
					state_nxt = agu_pkg::S_IDLE;
			end
			default: state_nxt = agu_pkg::S_IDLE;
		endcase
	end

	assign done = (state == agu_pkg::S_WBCK) & o_ready;

	always_ff @(posedge clk) begin
		if (rst)
			state <= agu_pkg::S_IDLE;
		else
			state <= state_nxt;
	end

	// keeps commit flags steady while the inputs are replayed
	always_ff @(posedge clk) begin
		if (rst)
			unalgn_held <= 1'b0;
		else if (start)
			unalgn_held <= addr_unalgn;
		else if (done)
			unalgn_held <= 1'b0;
	end

endmodule

`default_nettype wire

// File: verilog/agu_pkg.sv
`default_nettype none

`include "agu_settings.svh"

package agu_pkg;

	typedef logic [`AGU_XLEN-1:0]      xlen_t;  // operands and data
	typedef logic [`AGU_ADDR_SIZE-1:0] addr_t;  // byte address
	typedef logic [`AGU_MASK_W-1:0]    wmask_t; // byte lanes
	typedef logic [1:0]                size_t;  // 0 byte, 1 half, 2 word

	typedef enum logic [1:0] {
		OP_LOAD  = 2'd0,
		OP_STORE = 2'd1,
		OP_AMO   = 2'd2
	} agu_op_t;

	// atomic read-modify-write flavours
	typedef enum logic [3:0] {
		AMO_SWAP = 4'd0,
		AMO_ADD  = 4'd1,
		AMO_AND  = 4'd2,
		AMO_OR   = 4'd3,
		AMO_XOR  = 4'd4,
		AMO_MAX  = 4'd5,
		AMO_MIN  = 4'd6,
		AMO_MAXU = 4'd7,
		AMO_MINU = 4'd8
	} amo_op_t;

	typedef enum logic [2:0] {
		S_IDLE        = 3'd0,
		S_FIRST       = 3'd1, // locked read issued, waiting for data
		S_ALU         = 3'd2,
		S_READY       = 3'd3,
		S_WAIT_SECOND = 3'd4, // write command pending
		S_SECOND      = 3'd5, // waiting for write response
		S_WBCK        = 3'd6
	} amo_state_t;

endpackage

`default_nettype wire

// File: verilog/agu_settings.svh
`ifndef AGU_SETTINGS_SVH
`define AGU_SETTINGS_SVH

// data path width, only 32 is supported
`define AGU_XLEN 32

// byte address width
`define AGU_ADDR_SIZE 32

// one write-enable bit per byte lane
`define AGU_MASK_W (`AGU_XLEN/8)

`endif

// File: verilog/agu_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "agu_settings.svh"

module agu_top (
	input  logic              clk,
	input  logic              rst,
	input  logic              i_valid,
	output logic              i_ready,
	input  agu_pkg::agu_op_t  i_op,
	input  agu_pkg::size_t    i_size,
	input  agu_pkg::amo_op_t  i_amo_op,
	input  agu_pkg::xlen_t    i_rs1,
	input  agu_pkg::xlen_t    i_rs2,
	input  agu_pkg::xlen_t    i_imm,
	input  logic              oitf_empty,
	output logic              amo_wait,
	output logic              o_valid,
	input  logic              o_ready,
	output agu_pkg::xlen_t    o_wbck_wdat,
	output logic              o_wbck_err,
	output logic              o_cmt_misalgn,
	output logic              o_cmt_buserr,
	output logic              o_cmt_ld,
	output logic              o_cmt_stamo,
	output agu_pkg::addr_t    o_cmt_badaddr,
	output logic              icb_cmd_valid,
	input  logic              icb_cmd_ready,
	output agu_pkg::addr_t    icb_cmd_addr,
	output logic              icb_cmd_read,
	output agu_pkg::xlen_t    icb_cmd_wdata,
	output agu_pkg::wmask_t   icb_cmd_wmask,
	output logic              icb_cmd_lock,
	output agu_pkg::size_t    icb_cmd_size,
	input  logic              icb_rsp_valid,
	input  logic              icb_rsp_err,
	input  agu_pkg::xlen_t    icb_rsp_rdata
);

	agu_pkg::addr_t      addr;
	logic                addr_unalgn;
	agu_pkg::xlen_t      st_wdata;
	agu_pkg::wmask_t     st_wmask;
	agu_pkg::amo_state_t state;
	logic                unalgn_held;
	logic                amo_done;
	logic                amo_start;
	agu_pkg::xlen_t      alu_result;
	agu_pkg::xlen_t      read_val;
	agu_pkg::xlen_t      write_val;
	logic                amo_err;

	logic is_idle;
	logic is_wait2;
	logic is_wbck;
	logic is_ld;
	logic is_st;
	logic is_amo;
	logic unalgn;
	logic algn_ldst;
	logic algn_amo;
	logic unalgn_any; // misaligned load, store or atomic

	agu_addr_gen u_addr_gen (
		.i_op        (i_op),
		.i_size      (i_size),
		.i_rs1       (i_rs1),
		.i_rs2       (i_rs2),
		.i_imm       (i_imm),
		.addr        (addr),
		.addr_unalgn (addr_unalgn),
		.st_wdata    (st_wdata),
		.st_wmask    (st_wmask)
	);

	agu_amo_fsm u_amo_fsm (
		.clk         (clk),
		.rst         (rst),
		.start       (amo_start),
		.addr_unalgn (addr_unalgn),
		.cmd_ready   (icb_cmd_ready),
		.rsp_valid   (icb_rsp_valid),
		.o_ready     (o_ready),
		.state       (state),
		.unalgn_held (unalgn_held),
		.done        (amo_done)
	);

	agu_amo_alu u_amo_alu (
		.amo_op  (i_amo_op),
		.mem_val (read_val),
		.rs2     (i_rs2),
		.result  (alu_result)
	);

	agu_amo_buf u_amo_buf (
		.clk        (clk),
		.rst        (rst),
		.state      (state),
		.rsp_valid  (icb_rsp_valid),
		.rsp_err    (icb_rsp_err),
		.rsp_rdata  (icb_rsp_rdata),
		.alu_result (alu_result),
		.read_val   (read_val),
		.write_val  (write_val),
		.err        (amo_err)
	);

	assign is_idle  = (state == agu_pkg::S_IDLE);
	assign is_wait2 = (state == agu_pkg::S_WAIT_SECOND);
	assign is_wbck  = (state == agu_pkg::S_WBCK);

	assign is_ld  = (i_op == agu_pkg::OP_LOAD);
	assign is_st  = (i_op == agu_pkg::OP_STORE);
	assign is_amo = (i_op == agu_pkg::OP_AMO);

	// live check in idle, held flag once a sequence runs
	assign unalgn     = is_idle ? addr_unalgn : unalgn_held;
	assign algn_ldst  = ~unalgn & (is_ld | is_st);
	assign algn_amo   = ~unalgn & is_amo;
	assign unalgn_any = unalgn & (is_ld | is_st | is_amo);

	// locked read in idle, the write in wait_second
	assign icb_cmd_valid = (algn_ldst & i_valid & o_ready)
		| (algn_amo & is_idle & i_valid & o_ready & oitf_empty)
		| (algn_amo & is_wait2);

	assign amo_start = algn_amo & is_idle & icb_cmd_valid & icb_cmd_ready;

	assign icb_cmd_addr  = addr;
	assign icb_cmd_read  = algn_amo ? is_idle : is_ld;
	assign icb_cmd_lock  = algn_amo & is_idle;
	assign icb_cmd_size  = i_size;
	assign icb_cmd_wdata = is_amo ? write_val : st_wdata;
	// a failed read must not modify memory
	assign icb_cmd_wmask = is_amo ? (amo_err ? '0 : {`AGU_MASK_W{1'b1}}) : st_wmask;

	assign o_valid = is_wbck
		| (i_valid & algn_ldst & icb_cmd_ready)
		| (i_valid & unalgn_any);

	assign i_ready = algn_amo ? amo_done
		: unalgn_any ? (i_valid & o_ready)
		: (i_valid & icb_cmd_ready & o_ready);

	assign amo_wait = ~is_idle;

	assign o_wbck_wdat   = algn_amo ? read_val : {`AGU_XLEN{1'b0}};
	assign o_cmt_buserr  = algn_amo & amo_err;
	assign o_cmt_misalgn = unalgn_any;
	assign o_wbck_err    = o_cmt_buserr | o_cmt_misalgn;
	assign o_cmt_badaddr = addr;
	assign o_cmt_ld      = is_ld;
	assign o_cmt_stamo   = is_st | is_amo;

endmodule

`default_nettype wire
